//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

   localparam int NUM_REGS  = 32;
   localparam int REG_IDX_W = 5;

   // Opcode in bits 31:27, unknown codes behave as NOP
   typedef enum logic [4:0] {
      NOP      = 5'd0,
      LOAD_IMM = 5'd1,
      LOAD_MEM = 5'd2,
      STORE    = 5'd3,
      ALU      = 5'd4,
      JUMP_NZ  = 5'd5,
      HALT     = 5'd6
   } instr_type_e;

   typedef enum logic [4:0] {
      ADD = 5'd0,
      SUB = 5'd1,
      AND = 5'd2,
      OR  = 5'd3,
      XOR = 5'd4,
      SHL = 5'd5,
      SLT = 5'd6
   } alu_op_e;

   typedef struct packed {
      logic [4:0]           opcode;
      logic [REG_IDX_W-1:0] rd;
      logic [REG_IDX_W-1:0] rs0;
      logic [REG_IDX_W-1:0] rs1;
      logic [4:0]           alu_op;
      logic [6:0]           unused;
   } reg_fmt_t;

   typedef struct packed {
      logic [4:0]           opcode;
      logic [REG_IDX_W-1:0] rd;
      logic [5:0]           pad;
      logic [15:0]          imm16;
   } imm_fmt_t;

   // Same word seen as register or immediate format
   typedef union packed {
      reg_fmt_t reg_fmt;
      imm_fmt_t imm_fmt;
   } instr_word_u;

   typedef enum logic [2:0] {
      FETCH     = 3'd0,
      DECODE    = 3'd1,
      EXECUTE   = 3'd2,
      MEMORY    = 3'd3,
      WRITEBACK = 3'd4
   } stage_e;

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

   localparam int AXI_ADDR_W = 12;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   // Host register map, byte offsets
   localparam logic [AXI_ADDR_W-1:0] CTRL_OFFSET   = 12'h000;
   localparam logic [AXI_ADDR_W-1:0] STATUS_OFFSET = 12'h004;

   // Word i of main memory sits at MEM_BASE + 4*i
   localparam logic [AXI_ADDR_W-1:0] MEM_BASE      = 12'h400;

endpackage

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
   input  wire logic [31:0]                  instr,
   output isa_pkg::instr_type_e              itype,
   output logic [isa_pkg::REG_IDX_W-1:0]     rd,
   output logic [isa_pkg::REG_IDX_W-1:0]     rs0,
   output logic [isa_pkg::REG_IDX_W-1:0]     rs1,
   output logic [31:0]                       imm,
   output isa_pkg::alu_op_e                  alu_op
);

   import isa_pkg::*;

   instr_word_u word;

   assign word = instr;

   always_comb begin
      case (word.reg_fmt.opcode)
         LOAD_IMM, LOAD_MEM, STORE, ALU, JUMP_NZ, HALT: begin
            itype = instr_type_e'(word.reg_fmt.opcode);
         end
         default: begin
            itype = NOP;
         end
      endcase

      // rd sits in the same bits in both formats
      rd = word.reg_fmt.rd;

      if (itype == LOAD_IMM) begin
         // Immediate view, imm16 sign extended
         rs0 = '0;
         rs1 = '0;
         imm = {{16{word.imm_fmt.imm16[15]}}, word.imm_fmt.imm16};
      end else begin
         rs0 = word.reg_fmt.rs0;
         rs1 = word.reg_fmt.rs1;
         imm = '0;
      end

      alu_op = alu_op_e'(word.reg_fmt.alu_op);
   end

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
   parameter  int MEM_DEPTH = 256,
   localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          start,
   output logic                               running,
   output logic                               halted,
   output logic [ADDR_W-1:0]                  fetch_addr,
   output logic [ADDR_W-1:0]                  data_addr,
   output logic [ADDR_W-1:0]                  wr_addr,
   input  wire logic [31:0]                   fetch_data,
   input  wire logic [31:0]                   data_rdata,
   output logic [31:0]                        wr_data,
   output logic                               wr_en,
   output logic [31:0]                        issued,
   input  isa_pkg::instr_type_e               itype,
   input  wire logic [isa_pkg::REG_IDX_W-1:0] rd,
   input  wire logic [isa_pkg::REG_IDX_W-1:0] rs0,
   input  wire logic [isa_pkg::REG_IDX_W-1:0] rs1,
   input  wire logic [31:0]                   imm,
   input  isa_pkg::alu_op_e                   alu_op
);

   import isa_pkg::*;

   stage_e            stage;
   logic [ADDR_W-1:0] pc;
   logic [ADDR_W-1:0] next_pc;
   logic [31:0]       issue_reg;
   logic [31:0]       regs [NUM_REGS];
   logic [31:0]       op_a;
   logic [31:0]       op_b;
   logic [31:0]       alu_out;
   logic [31:0]       alu_res;
   logic [31:0]       wb_data;
   logic              reg_wen;

   // Fetched word is decoded straight from memory during DECODE
   assign issued = (stage == DECODE) ? fetch_data : issue_reg;

   assign fetch_addr = pc;
   assign data_addr  = op_a[ADDR_W-1:0];
   assign wr_addr    = op_b[ADDR_W-1:0];
   assign wr_data    = op_a;
   assign wr_en      = running && (stage == MEMORY) && (itype == STORE);

   always_comb begin
      case (alu_op)
         ADD:     alu_out = op_a + op_b;
         SUB:     alu_out = op_a - op_b;
         AND:     alu_out = op_a & op_b;
         OR:      alu_out = op_a | op_b;
         XOR:     alu_out = op_a ^ op_b;
         SHL:     alu_out = op_a << op_b[4:0];
         SLT:     alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         default: alu_out = '0;
      endcase
   end

   // Write-back source by instruction type
   always_comb begin
      case (itype)
         LOAD_IMM: wb_data = imm;
         LOAD_MEM: wb_data = data_rdata;
         default:  wb_data = alu_res;
      endcase
   end

   assign reg_wen = running && (stage == WRITEBACK) && (rd != '0) &&
                    (itype == LOAD_IMM || itype == LOAD_MEM || itype == ALU);

   always_comb begin
      if (itype == JUMP_NZ && op_a != '0) begin
         next_pc = op_b[ADDR_W-1:0];
      end else if (32'(pc) == MEM_DEPTH - 1) begin
         next_pc = '0;
      end else begin
         next_pc = pc + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         stage     <= FETCH;
         pc        <= '0;
         running   <= 1'b0;
         halted    <= 1'b0;
         issue_reg <= '0;
      end else if (start && !running) begin
         stage   <= FETCH;
         pc      <= '0;
         running <= 1'b1;
         halted  <= 1'b0;
      end else if (running) begin
         case (stage)
            FETCH:   stage <= DECODE;
            DECODE: begin
               stage     <= EXECUTE;
               issue_reg <= fetch_data;
            end
            EXECUTE: stage <= MEMORY;
            MEMORY:  stage <= WRITEBACK;
            WRITEBACK: begin
               stage <= FETCH;
               if (itype == HALT) begin
                  running <= 1'b0;
                  halted  <= 1'b1;
               end else begin
                  pc <= next_pc;
               end
            end
            default: stage <= FETCH;
         endcase
      end
   end

   // Operands, ALU result and register file
   always_ff @(posedge clk) begin
      if (running && stage == DECODE) begin
         op_a <= (rs0 == '0) ? '0 : regs[rs0];
         op_b <= (rs1 == '0) ? '0 : regs[rs1];
      end
      if (running && stage == EXECUTE) begin
         alu_res <= alu_out;
      end
      if (reg_wen) begin
         regs[rd] <= wb_data;
      end
   end

endmodule

`default_nettype wire

//--- design/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
   parameter  int MEM_DEPTH = 256,
   localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
   input  wire logic              clk,
   input  wire logic              core_sel,
   input  wire logic [ADDR_W-1:0] raddr0,
   input  wire logic [ADDR_W-1:0] raddr1,
   output logic [31:0]            rdata0,
   output logic [31:0]            rdata1,
   input  wire logic [ADDR_W-1:0] waddr,
   input  wire logic [31:0]       wdata,
   input  wire logic              wen,
   input  wire logic [ADDR_W-1:0] host_raddr,
   output logic [31:0]            host_rdata,
   input  wire logic [ADDR_W-1:0] host_waddr,
   input  wire logic [31:0]       host_wdata,
   input  wire logic              host_wen
);

   logic [31:0]       mem [MEM_DEPTH];
   logic [31:0]       q0;
   logic [31:0]       q1;
   logic [ADDR_W-1:0] addr1;
   logic [ADDR_W-1:0] wa;
   logic [31:0]       wd;
   logic              we;

   // Port 1 and the write port go to the host when the core is idle
   assign addr1 = core_sel ? raddr1 : host_raddr;
   assign wa    = core_sel ? waddr : host_waddr;
   assign wd    = core_sel ? wdata : host_wdata;
   assign we    = core_sel ? wen : host_wen;

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wa] <= wd;
      end
      q0 <= mem[raddr0];
      q1 <= mem[addr1];
   end

   assign rdata0     = q0;
   assign rdata1     = q1;
   assign host_rdata = q1;

endmodule

`default_nettype wire

//--- design/axil_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_host_port #(
   parameter  int MEM_DEPTH = 256,
   localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic [bus_pkg::AXI_ADDR_W-1:0] awaddr,
   input  wire logic                           awvalid,
   output logic                                awready,
   input  wire logic [31:0]                    wdata,
   input  wire logic [3:0]                     wstrb,
   input  wire logic                           wvalid,
   output logic                                wready,
   output bus_pkg::axi_resp_e                  bresp,
   output logic                                bvalid,
   input  wire logic                           bready,
   input  wire logic [bus_pkg::AXI_ADDR_W-1:0] araddr,
   input  wire logic                           arvalid,
   output logic                                arready,
   output logic [31:0]                         rdata,
   output bus_pkg::axi_resp_e                  rresp,
   output logic                                rvalid,
   input  wire logic                           rready,
   output logic                                start,
   input  wire logic                           running,
   input  wire logic                           halted,
   output logic [ADDR_W-1:0]                   mem_raddr,
   input  wire logic [31:0]                    mem_rdata,
   output logic [ADDR_W-1:0]                   mem_waddr,
   output logic [31:0]                         mem_wdata,
   output logic                                mem_wen
);

   import bus_pkg::*;

   logic rd_pend;

   function automatic logic in_window(input logic [AXI_ADDR_W-1:0] a);
      logic [31:0] lin;
      lin = 32'(a);
      return (lin >= 32'(MEM_BASE)) && (lin < 32'(MEM_BASE) + 32'(MEM_DEPTH) * 32'd4);
   endfunction

   function automatic logic [ADDR_W-1:0] mem_index(input logic [AXI_ADDR_W-1:0] a);
      logic [31:0] off;
      off = 32'(a) - 32'(MEM_BASE);
      return off[ADDR_W+1:2];
   endfunction

   assign mem_raddr = mem_index(araddr);
   assign mem_waddr = mem_index(awaddr);
   assign mem_wdata = wdata;
   // Full-word writes only, and never while the core owns memory
   assign mem_wen   = awready && in_window(awaddr) && !running && (wstrb == 4'hf);

   // Write channel
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= OKAY;
         start   <= 1'b0;
      end else begin
         awready <= awvalid && wvalid && !awready && !bvalid;
         wready  <= awvalid && wvalid && !awready && !bvalid;
         start   <= awready && (awaddr == CTRL_OFFSET) && wdata[0];
         if (awready) begin
            bvalid <= 1'b1;
            // Status is read-only
            if (awaddr == CTRL_OFFSET || mem_wen) begin
               bresp <= OKAY;
            end else begin
               bresp <= SLVERR;
            end
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // Read channel, memory reads wait one extra cycle for the array
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rd_pend <= 1'b0;
         rdata   <= '0;
         rresp   <= OKAY;
      end else begin
         arready <= arvalid && !arready && !rvalid && !rd_pend;
         if (arready) begin
            if (in_window(araddr) && !running) begin
               rd_pend <= 1'b1;
            end else begin
               rvalid <= 1'b1;
               rdata  <= '0;
               rresp  <= SLVERR;
               if (araddr == STATUS_OFFSET) begin
                  rdata <= {30'b0, halted, running};
                  rresp <= OKAY;
               end else if (araddr == CTRL_OFFSET) begin
                  rresp <= OKAY;
               end
            end
         end else if (rd_pend) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= mem_rdata;
            rresp   <= OKAY;
         end else if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
   parameter  int MEM_DEPTH = 256,
   localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic [bus_pkg::AXI_ADDR_W-1:0] awaddr,
   input  wire logic                           awvalid,
   output logic                                awready,
   input  wire logic [31:0]                    wdata,
   input  wire logic [3:0]                     wstrb,
   input  wire logic                           wvalid,
   output logic                                wready,
   output bus_pkg::axi_resp_e                  bresp,
   output logic                                bvalid,
   input  wire logic                           bready,
   input  wire logic [bus_pkg::AXI_ADDR_W-1:0] araddr,
   input  wire logic                           arvalid,
   output logic                                arready,
   output logic [31:0]                         rdata,
   output bus_pkg::axi_resp_e                  rresp,
   output logic                                rvalid,
   input  wire logic                           rready
);

   import isa_pkg::*;

   logic                 start;
   logic                 running;
   logic                 halted;
   logic [ADDR_W-1:0]    host_raddr;
   logic [31:0]          host_rdata;
   logic [ADDR_W-1:0]    host_waddr;
   logic [31:0]          host_wdata;
   logic                 host_wen;
   logic [ADDR_W-1:0]    fetch_addr;
   logic [ADDR_W-1:0]    data_addr;
   logic [ADDR_W-1:0]    wr_addr;
   logic [31:0]          fetch_data;
   logic [31:0]          data_rdata;
   logic [31:0]          wr_data;
   logic                 wr_en;
   logic [31:0]          issued;
   instr_type_e          itype;
   logic [REG_IDX_W-1:0] rd;
   logic [REG_IDX_W-1:0] rs0;
   logic [REG_IDX_W-1:0] rs1;
   logic [31:0]          imm;
   alu_op_e              alu_op;

   axil_host_port #(.MEM_DEPTH(MEM_DEPTH)) host_port_i (
      .clk(clk), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .start(start), .running(running), .halted(halted),
      .mem_raddr(host_raddr), .mem_rdata(host_rdata),
      .mem_waddr(host_waddr), .mem_wdata(host_wdata), .mem_wen(host_wen)
   );

   // Core owns the memory for as long as it runs
   main_memory #(.MEM_DEPTH(MEM_DEPTH)) main_memory_i (
      .clk(clk), .core_sel(running),
      .raddr0(fetch_addr), .raddr1(data_addr),
      .rdata0(fetch_data), .rdata1(data_rdata),
      .waddr(wr_addr), .wdata(wr_data), .wen(wr_en),
      .host_raddr(host_raddr), .host_rdata(host_rdata),
      .host_waddr(host_waddr), .host_wdata(host_wdata), .host_wen(host_wen)
   );

   cpu_core #(.MEM_DEPTH(MEM_DEPTH)) cpu_core_i (
      .clk(clk), .rst(rst), .start(start),
      .running(running), .halted(halted),
      .fetch_addr(fetch_addr), .data_addr(data_addr), .wr_addr(wr_addr),
      .fetch_data(fetch_data), .data_rdata(data_rdata),
      .wr_data(wr_data), .wr_en(wr_en), .issued(issued),
      .itype(itype), .rd(rd), .rs0(rs0), .rs1(rs1), .imm(imm), .alu_op(alu_op)
   );

   instr_decoder instr_decoder_i (
      .instr(issued),
      .itype(itype), .rd(rd), .rs0(rs0), .rs1(rs1), .imm(imm), .alu_op(alu_op)
   );

endmodule

`default_nettype wire

//--- test/cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
   input wire logic                           clk,
   input wire logic                           rst,
   input wire logic [bus_pkg::AXI_ADDR_W-1:0] awaddr,
   input wire logic                           awready,
   input wire logic [1:0]                     bresp,
   input wire logic                           bvalid,
   input wire logic                           bready,
   input wire logic                           rvalid,
   input wire logic                           rready,
   input wire logic                           running,
   input wire logic                           halted
);

   import bus_pkg::*;

   // Responses stay up until the host takes them
   bvalid_held: assert property (@(posedge clk) disable iff (!rst)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   rvalid_held: assert property (@(posedge clk) disable iff (!rst)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // Host writes into memory fail while the core runs
   busy_write_refused: assert property (@(posedge clk) disable iff (!rst)
      awready && running && (awaddr >= MEM_BASE) |=> bvalid && (bresp == SLVERR))
      else $error("memory write accepted while core running");

   run_state_exclusive: assert property (@(posedge clk) disable iff (!rst)
      !(running && halted))
      else $error("running and halted both high");

endmodule

bind cpu_top cpu_assertions assertions_i (
   .clk(clk),
   .rst(rst),
   .awaddr(awaddr),
   .awready(awready),
   .bresp(bresp),
   .bvalid(bvalid),
   .bready(bready),
   .rvalid(rvalid),
   .rready(rready),
   .running(running),
   .halted(halted)
);

`default_nettype wire

//--- test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

   import isa_pkg::*;
   import bus_pkg::*;

   localparam int MEM_DEPTH   = 256;
   localparam int ADDR_W      = $clog2(MEM_DEPTH);
   // Whole run needs about 1500 cycles
   localparam int TIMEOUT_CYCLES = 5000;
   localparam int HS_LIMIT    = 20;
   localparam int HALT_POLLS  = 200;
   localparam int MODEL_STEPS = 2000;

   logic        clk;
   logic        rst;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   int errors = 0;
   int checks = 0;
   int cycle_count = 0;

   // Mirror of DUT memory, updated by host writes and the reference model
   logic [31:0] model_mem [MEM_DEPTH];
   logic [31:0] prog [$];

   cpu_top #(.MEM_DEPTH(MEM_DEPTH)) dut_i (
      .clk(clk), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   function automatic logic [31:0] imm_word(input logic [4:0] rd, input logic [15:0] imm16);
      instr_word_u w;
      w = '0;
      w.imm_fmt.opcode = LOAD_IMM;
      w.imm_fmt.rd = rd;
      w.imm_fmt.imm16 = imm16;
      return w;
   endfunction

   function automatic logic [31:0] reg_word(input logic [4:0] opc, input logic [4:0] rd,
                                            input logic [4:0] rs0, input logic [4:0] rs1,
                                            input logic [4:0] aop);
      instr_word_u w;
      w = '0;
      w.reg_fmt.opcode = opc;
      w.reg_fmt.rd = rd;
      w.reg_fmt.rs0 = rs0;
      w.reg_fmt.rs1 = rs1;
      w.reg_fmt.alu_op = aop;
      return w;
   endfunction

   function automatic logic [11:0] mem_addr(input logic [ADDR_W-1:0] idx);
      return MEM_BASE + 12'({idx, 2'b00});
   endfunction

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      int waited;
      @(posedge clk);
      #1;
      awaddr = addr;
      wdata = data;
      wstrb = 4'hf;
      awvalid = 1'b1;
      wvalid = 1'b1;
      waited = 0;
      @(negedge clk);
      while (!(awready && wready) && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!(awready && wready)) begin
         $display("ERROR: write to 0x%h was never accepted", addr);
         errors++;
      end
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = 1'b1;
      waited = 0;
      @(negedge clk);
      while (!bvalid && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!bvalid) begin
         $display("ERROR: no write response for address 0x%h", addr);
         errors++;
      end
      resp = bresp;
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int waited;
      @(posedge clk);
      #1;
      araddr = addr;
      arvalid = 1'b1;
      waited = 0;
      @(negedge clk);
      while (!arready && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!arready) begin
         $display("ERROR: read of 0x%h was never accepted", addr);
         errors++;
      end
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      rready = 1'b1;
      waited = 0;
      @(negedge clk);
      while (!rvalid && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!rvalid) begin
         $display("ERROR: no read data for address 0x%h", addr);
         errors++;
      end
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   task automatic load_word(input logic [ADDR_W-1:0] idx, input logic [31:0] data);
      logic [1:0] resp;
      axil_write(mem_addr(idx), data, resp);
      check($sformatf("bresp[%0h]", idx), 32'(resp), 32'(OKAY));
      model_mem[idx] = data;
   endtask

   task automatic compare_word(input logic [ADDR_W-1:0] idx);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(mem_addr(idx), data, resp);
      check($sformatf("rresp[%0h]", idx), 32'(resp), 32'(OKAY));
      check($sformatf("mem[%0h]", idx), data, model_mem[idx]);
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         load_word(ADDR_W'(i), prog[i]);
      end
   endtask

   task automatic start_core();
      logic [1:0] resp;
      axil_write(CTRL_OFFSET, 32'h1, resp);
      check("bresp ctrl", 32'(resp), 32'(OKAY));
   endtask

   task automatic wait_halt();
      logic [31:0] status;
      logic [1:0]  resp;
      int          polls;
      polls = 0;
      status = '0;
      while (!status[1] && polls < HALT_POLLS) begin
         axil_read(STATUS_OFFSET, status, resp);
         polls++;
      end
      if (!status[1]) begin
         $display("ERROR: core did not halt after %0d status polls", polls);
         errors++;
      end
   endtask

   function automatic logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
      case (op)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         SHL:     return a << b[4:0];
         SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: return '0;
      endcase
   endfunction

   // Instruction-level model of the ISA, runs on the memory mirror
   task automatic run_model();
      logic [31:0]       regs [NUM_REGS];
      instr_word_u       w;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [ADDR_W-1:0] pc;
      logic [ADDR_W-1:0] pc_next;
      int                steps;
      logic              done;
      regs = '{default: '0};
      pc = '0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < MODEL_STEPS) begin
         w = model_mem[pc];
         a = regs[w.reg_fmt.rs0];
         b = regs[w.reg_fmt.rs1];
         pc_next = pc + ADDR_W'(1);
         case (w.reg_fmt.opcode)
            LOAD_IMM: regs[w.imm_fmt.rd] = {{16{w.imm_fmt.imm16[15]}}, w.imm_fmt.imm16};
            LOAD_MEM: regs[w.reg_fmt.rd] = model_mem[a[ADDR_W-1:0]];
            STORE:    model_mem[b[ADDR_W-1:0]] = a;
            ALU:      regs[w.reg_fmt.rd] = alu_model(w.reg_fmt.alu_op, a, b);
            JUMP_NZ: begin
               if (a != '0) begin
                  pc_next = b[ADDR_W-1:0];
               end
            end
            HALT:     done = 1'b1;
            default:  ;
         endcase
         regs[0] = '0;
         pc = pc_next;
         steps++;
      end
      if (!done) begin
         $display("ERROR: reference model never reached HALT");
         errors++;
      end
   endtask

   task automatic after_reset();
      logic [31:0] data;
      logic [1:0]  resp;
      check("awready", 32'(awready), 32'h0);
      check("bvalid", 32'(bvalid), 32'h0);
      check("arready", 32'(arready), 32'h0);
      check("rvalid", 32'(rvalid), 32'h0);
      axil_read(STATUS_OFFSET, data, resp);
      check("status", data, 32'h0);
      check("rresp status", 32'(resp), 32'(OKAY));
   endtask

   task automatic memory_readback();
      for (int i = 0; i < 16; i++) begin
         load_word(ADDR_W'(8'h80 + i), $urandom());
      end
      for (int i = 0; i < 16; i++) begin
         compare_word(ADDR_W'(8'h80 + i));
      end
   endtask

   task automatic arith_program();
      logic [4:0]  src;
      logic [31:0] data;
      logic [1:0]  resp;
      prog.delete();
      prog.push_back(imm_word(5'd0, 16'h0055));
      prog.push_back(imm_word(5'd1, 16'h1234));
      prog.push_back(imm_word(5'd2, 16'hfff6));
      prog.push_back(imm_word(5'd20, 16'h0060));
      prog.push_back(imm_word(5'd21, 16'h0001));
      // r4..r10 get ADD through SLT of r1 and r2
      for (int k = 0; k < 7; k++) begin
         prog.push_back(reg_word(ALU, 5'(4 + k), 5'd1, 5'd2, 5'(k)));
      end
      prog.push_back(reg_word(ALU, 5'd11, 5'd2, 5'd1, SLT));
      // Store r0, r2, r4..r11 to words 0x60 upward
      for (int k = 0; k < 10; k++) begin
         src = (k < 2) ? 5'(2 * k) : 5'(k + 2);
         prog.push_back(reg_word(STORE, 5'd0, src, 5'd20, ADD));
         prog.push_back(reg_word(ALU, 5'd20, 5'd20, 5'd21, ADD));
      end
      prog.push_back(reg_word(HALT, 5'd0, 5'd0, 5'd0, ADD));
      load_program();
      run_model();
      start_core();
      wait_halt();
      for (int k = 0; k < 10; k++) begin
         compare_word(ADDR_W'(8'h60 + k));
      end
      axil_read(mem_addr(8'h60), data, resp);
      check("mem[60] r0", data, 32'h0);
      axil_read(mem_addr(8'h61), data, resp);
      check("mem[61] sign extended", data, 32'hffff_fff6);
   endtask

   task automatic branch_program();
      logic [31:0] data;
      logic [1:0]  resp;
      for (int i = 0; i < 8; i++) begin
         load_word(ADDR_W'(8'h40 + i), $urandom());
      end
      prog.delete();
      prog.push_back(imm_word(5'd1, 16'h0040));
      prog.push_back(imm_word(5'd2, 16'd8));
      prog.push_back(imm_word(5'd3, 16'd0));
      prog.push_back(imm_word(5'd4, 16'd1));
      prog.push_back(imm_word(5'd5, 16'd7));
      prog.push_back(imm_word(5'd8, 16'd0));
      prog.push_back(imm_word(5'd9, 16'h0050));
      // Loop body at word 7, counts r2 down to zero
      prog.push_back(reg_word(LOAD_MEM, 5'd6, 5'd1, 5'd0, ADD));
      prog.push_back(reg_word(ALU, 5'd3, 5'd3, 5'd6, ADD));
      prog.push_back(reg_word(ALU, 5'd1, 5'd1, 5'd4, ADD));
      prog.push_back(reg_word(ALU, 5'd8, 5'd8, 5'd4, ADD));
      prog.push_back(reg_word(ALU, 5'd2, 5'd2, 5'd4, SUB));
      prog.push_back(reg_word(JUMP_NZ, 5'd0, 5'd2, 5'd5, ADD));
      prog.push_back(reg_word(STORE, 5'd0, 5'd3, 5'd9, ADD));
      prog.push_back(reg_word(ALU, 5'd9, 5'd9, 5'd4, ADD));
      prog.push_back(reg_word(STORE, 5'd0, 5'd8, 5'd9, ADD));
      prog.push_back(reg_word(HALT, 5'd0, 5'd0, 5'd0, ADD));
      load_program();
      run_model();
      start_core();
      wait_halt();
      compare_word(8'h50);
      compare_word(8'h51);
      axil_read(mem_addr(8'h51), data, resp);
      check("mem[51] loop count", data, 32'd8);
   endtask

   task automatic running_errors();
      logic [31:0] guard;
      logic [31:0] data;
      logic [1:0]  resp;
      guard = $urandom();
      // Clear old results so the rerun shows up
      load_word(8'h50, '0);
      load_word(8'h51, '0);
      load_word(8'h90, guard);
      start_core();
      axil_read(STATUS_OFFSET, data, resp);
      check("status running", data, 32'h1);
      axil_write(mem_addr(8'h90), ~guard, resp);
      check("bresp running write", 32'(resp), 32'(SLVERR));
      axil_read(mem_addr(8'h90), data, resp);
      check("rresp running read", 32'(resp), 32'(SLVERR));
      check("rdata running read", data, 32'h0);
      wait_halt();
      run_model();
      compare_word(8'h50);
      compare_word(8'h51);
      compare_word(8'h90);
      axil_read(12'h100, data, resp);
      check("rresp unmapped", 32'(resp), 32'(SLVERR));
      check("rdata unmapped", data, 32'h0);
      axil_write(12'h100, 32'hffff_ffff, resp);
      check("bresp unmapped", 32'(resp), 32'(SLVERR));
      axil_read(STATUS_OFFSET, data, resp);
      check("status halted", data, 32'h2);
   endtask

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("ERROR: run stopped by timeout after %0d cycles", cycle_count);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      void'($urandom(32'h7a));
      rst = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      model_mem = '{default: '0};
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b1;
      after_reset();
      memory_readback();
      arith_program();
      branch_program();
      running_errors();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
design/isa_pkg.sv
design/bus_pkg.sv
design/instr_decoder.sv
design/cpu_core.sv
design/main_memory.sv
design/axil_host_port.sv
design/cpu_top.sv
test/cpu_assertions.sv
test/cpu_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := cpu_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf $(OBJ_DIR)
